/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_fft_bfly
FILE_LIST  := list.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/bfly_addsub.sv */
/*
 * butterfly input stage: registered A + B and A - B per component
 */
`timescale 1ns/100ps

module bfly_addsub
    import fft_bfly_pkg::*;
#(
    parameter int DATA_W = fft_bfly_pkg::DATA_W
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic signed [DATA_W-1:0] a_re,
    input  logic signed [DATA_W-1:0] a_im,
    input  logic signed [DATA_W-1:0] b_re,
    input  logic signed [DATA_W-1:0] b_im,
    output logic signed [DATA_W:0]   sum_re,
    output logic signed [DATA_W:0]   sum_im,
    output logic signed [DATA_W:0]   diff_re,
    output logic signed [DATA_W:0]   diff_im,
    output logic                     pair_valid
);

    // operands widened before the add so the carry is kept
    logic signed [DATA_W:0] a_re_x, a_im_x, b_re_x, b_im_x;

    assign a_re_x = {a_re[DATA_W-1], a_re};
    assign a_im_x = {a_im[DATA_W-1], a_im};
    assign b_re_x = {b_re[DATA_W-1], b_re};
    assign b_im_x = {b_im[DATA_W-1], b_im};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_re     <= '0;
            sum_im     <= '0;
            diff_re    <= '0;
            diff_im    <= '0;
            pair_valid <= 1'b0;
        end else begin
            sum_re     <= a_re_x + b_re_x;
            sum_im     <= a_im_x + b_im_x;
            diff_re    <= a_re_x - b_re_x;
            diff_im    <= a_im_x - b_im_x;
            pair_valid <= in_valid;
        end
    end

    // marker feeds both the delay lane and the output
    pair_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(pair_valid)
    );

endmodule

/* hdl/cmul.sv */
/*
 * two-stage complex multiplier, (d_re + j d_im) * (w_re + j w_im)
 * with the Q2.14 scale removed by an arithmetic shift
 */
`timescale 1ns/100ps

module cmul
    import fft_bfly_pkg::*;
#(
    parameter int DATA_W  = fft_bfly_pkg::DATA_W,
    parameter int TW_FRAC = fft_bfly_pkg::TW_FRAC
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic signed [DATA_W:0]   diff_re,
    input  logic signed [DATA_W:0]   diff_im,
    input  logic signed [TW_W-1:0]   w_re,
    input  logic signed [TW_W-1:0]   w_im,
    output logic signed [DATA_W+1:0] y_re,
    output logic signed [DATA_W+1:0] y_im
);

    localparam int PROD_W = DATA_W + 1 + TW_W;

    // partial products, stage one
    logic signed [PROD_W-1:0] p_rr, p_ii, p_ri, p_ir;
    // combined sums, one extra bit before the shift
    logic signed [PROD_W:0]   re_full, im_full;
    logic signed [PROD_W:0]   re_shift, im_shift;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p_rr <= '0;
            p_ii <= '0;
            p_ri <= '0;
            p_ir <= '0;
        end else begin
            p_rr <= diff_re * w_re;
            p_ii <= diff_im * w_im;
            p_ri <= diff_re * w_im;
            p_ir <= diff_im * w_re;
        end
    end

    assign re_full  = p_rr - p_ii;
    assign im_full  = p_ri + p_ir;
    // floor, no rounding constant
    assign re_shift = re_full >>> TW_FRAC;
    assign im_shift = im_full >>> TW_FRAC;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y_re <= '0;
            y_im <= '0;
        end else begin
            y_re <= re_shift[DATA_W+1:0];
            y_im <= im_shift[DATA_W+1:0];
        end
    end

    // twiddle from the lookup stays on the unit circle
    twiddle_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (w_re <= TW_ONE) && (w_re >= -TW_ONE) && (w_im <= TW_ONE) && (w_im >= -TW_ONE)
    );

endmodule

/* hdl/fft_bfly_pkg.sv */
/*
 * widths, angle split and fixed-point constants shared by the
 * radix-2 butterfly datapath and its testbench
 */
package fft_bfly_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sample widths

    // one signed component of A or B
    parameter int DATA_W     = 16;
    // sum or difference, one bit of growth
    parameter int SUM_W      = DATA_W + 1;
    // Y component after the twiddle multiply
    parameter int PROD_OUT_W = DATA_W + 2;

    ////////////////////////////////////////////////////////////////////////////
    // angle split

    // full circle in 256 steps
    parameter int PHASE_W     = 8;
    // top two bits pick the quadrant
    parameter int QUAD_IDX_W  = PHASE_W - 2;
    // quarter wave plus the end point at 90 degrees
    parameter int TABLE_DEPTH = (2 ** QUAD_IDX_W) + 1;

    ////////////////////////////////////////////////////////////////////////////
    // twiddle format, signed Q2.14

    parameter int TW_W    = 16;
    parameter int TW_FRAC = 14;
    parameter int TW_ONE  = 2 ** TW_FRAC;

    // quarter sine table, entry k = round(16384 * sin(k * pi / 128))
    parameter string TABLE_FILE = "hdl/quarter_sin.hex";

endpackage

/* hdl/fft_bfly_top.sv */
/*
 * radix-2 FFT butterfly, X = A + B and Y = (A - B) * W,
 * three cycles from input to output, one pair per cycle
 */
`timescale 1ns/100ps

module fft_bfly_top
    import fft_bfly_pkg::*;
#(
    parameter int DATA_W = fft_bfly_pkg::DATA_W,
    parameter int DEPTH  = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic [PHASE_W-1:0]       wn_exp,
    input  logic signed [DATA_W-1:0] a_re,
    input  logic signed [DATA_W-1:0] a_im,
    input  logic signed [DATA_W-1:0] b_re,
    input  logic signed [DATA_W-1:0] b_im,
    output logic                     out_valid,
    output logic signed [DATA_W:0]   x_re,
    output logic signed [DATA_W:0]   x_im,
    output logic signed [DATA_W+1:0] y_re,
    output logic signed [DATA_W+1:0] y_im
);

    logic signed [DATA_W:0] sum_re, sum_im;
    logic signed [DATA_W:0] diff_re, diff_im;
    logic                   pair_valid;
    logic signed [TW_W-1:0] w_re, w_im;
    logic [2*DATA_W+1:0]    x_pair;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, sum/difference and twiddle lookup side by side

    bfly_addsub #(.DATA_W(DATA_W)) addsub_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .a_re       (a_re),
        .a_im       (a_im),
        .b_re       (b_re),
        .b_im       (b_im),
        .sum_re     (sum_re),
        .sum_im     (sum_im),
        .diff_re    (diff_re),
        .diff_im    (diff_im),
        .pair_valid (pair_valid)
    );

    twiddle_rom twiddle_i (
        .clk    (clk),
        .reset  (reset),
        .wn_exp (wn_exp),
        .w_re   (w_re),
        .w_im   (w_im)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stages 2 and 3, multiply on Y, plain delay on X

    cmul #(.DATA_W(DATA_W), .TW_FRAC(TW_FRAC)) cmul_i (
        .clk     (clk),
        .reset   (reset),
        .diff_re (diff_re),
        .diff_im (diff_im),
        .w_re    (w_re),
        .w_im    (w_im),
        .y_re    (y_re),
        .y_im    (y_im)
    );

    // depth matches the multiplier latency
    lane_delay #(.WIDTH(2 * (DATA_W + 1)), .DEPTH(DEPTH)) x_delay_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pair_valid),
        .in_data   ({sum_re, sum_im}),
        .out_valid (out_valid),
        .out_data  (x_pair)
    );

    assign x_re = x_pair[2*DATA_W+1 -: DATA_W+1];
    assign x_im = x_pair[DATA_W:0];

endmodule

/* hdl/lane_delay.sv */
/*
 * fixed-depth shift register for a data word and its valid flag
 */
`timescale 1ns/100ps

module lane_delay #(
    parameter int WIDTH = 34,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data
);

    logic [WIDTH-1:0] data_q [DEPTH];
    logic [DEPTH-1:0] valid_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            for (int k = 0; k < DEPTH; k++) begin
                data_q[k] <= '0;
            end
        end else begin
            valid_q[0] <= in_valid;
            data_q[0]  <= in_data;
            for (int k = 1; k < DEPTH; k++) begin
                valid_q[k] <= valid_q[k-1];
                data_q[k]  <= data_q[k-1];
            end
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

    // top level output qualifier, must be clean once out of reset
    out_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(out_valid)
    );

endmodule

/* hdl/quarter_sin.hex */
// quarter sine table, one Q2.14 word per line, entry k = round(16384 * sin(k * pi / 128))
0000
0192
0324
04B5
0646
07D6
0964
0AF1
0C7C
0E06
0F8D
1112
1294
1413
1590
1709
187E
19EF
1B5D
1CC6
1E2B
1F8C
20E7
223D
238E
24DA
2620
2760
289A
29CE
2AFB
2C21
2D41
2E5A
2F6C
3076
3179
3274
3368
3453
3537
3612
36E5
37B0
3871
392B
39DB
3A82
3B21
3BB6
3C42
3CC5
3D3F
3DAF
3E15
3E72
3EC5
3F0F
3F4F
3F85
3FB1
3FD4
3FEC
3FFB
4000

/* hdl/twiddle_rom.sv */
/*
 * twiddle factor lookup: quadrant folding over a quarter-wave sine
 * table, two reads per cycle, registered cos/sin pair
 */
`timescale 1ns/100ps

module twiddle_rom
    import fft_bfly_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [PHASE_W-1:0]     wn_exp,
    output logic signed [TW_W-1:0] w_re,
    output logic signed [TW_W-1:0] w_im
);

    localparam int QUARTER = 2 ** QUAD_IDX_W;

    // sin over [0, 90] degrees, both ends stored exactly
    logic signed [TW_W-1:0] table_mem [TABLE_DEPTH];

    initial begin
        $readmemh(TABLE_FILE, table_mem);
    end

    logic [1:0]             quad;
    logic [QUAD_IDX_W-1:0]  idx;
    logic [QUAD_IDX_W:0]    addr_lo;
    logic [QUAD_IDX_W:0]    addr_hi;
    logic signed [TW_W-1:0] t_lo;
    logic signed [TW_W-1:0] t_hi;
    logic signed [TW_W-1:0] cos_val;
    logic signed [TW_W-1:0] sin_val;

    assign quad = wn_exp[PHASE_W-1 -: 2];
    assign idx  = wn_exp[QUAD_IDX_W-1:0];

    // T[i] and T[64 - i], the latter is cos of the in-quadrant angle
    assign addr_lo = {1'b0, idx};
    assign addr_hi = (QUAD_IDX_W + 1)'(QUARTER) - addr_lo;
    assign t_lo    = table_mem[addr_lo];
    assign t_hi    = table_mem[addr_hi];

    ////////////////////////////////////////////////////////////////////////////
    // quadrant folding

    always_comb begin
        unique case (quad)
            2'd0: begin
                cos_val = t_hi;
                sin_val = t_lo;
            end
            2'd1: begin
                cos_val = -t_lo;
                sin_val = t_hi;
            end
            2'd2: begin
                cos_val = -t_hi;
                sin_val = -t_lo;
            end
            default: begin
                cos_val = t_lo;
                sin_val = -t_hi;
            end
        endcase
    end

    // lines up with the add/sub register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_re <= '0;
            w_im <= '0;
        end else begin
            w_re <= cos_val;
            w_im <= sin_val;
        end
    end

endmodule

/* list.f */
hdl/fft_bfly_pkg.sv
hdl/bfly_addsub.sv
hdl/twiddle_rom.sv
hdl/cmul.sv
hdl/lane_delay.sv
hdl/fft_bfly_top.sv
tests/tb_fft_bfly.sv

/* tests/tb_fft_bfly.sv */
/*
 * testbench for the radix-2 butterfly: clock, reset, random pairs,
 * reference model with its own twiddle lookup, output checks, timeout
 */
`timescale 1ns/100ps

module tb_fft_bfly
    import fft_bfly_pkg::*;
();

    localparam int NUM_VECTORS    = 600;
    localparam int LATENCY        = 3;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS * LATENCY + 200;
    localparam int RESET_CYCLES   = 8;
    // first vectors sweep the four quarter turns
    localparam int DIRECTED       = 16;
    localparam int QUARTER        = 2 ** QUAD_IDX_W;

    localparam logic signed [DATA_W-1:0] MAX_POS = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic signed [DATA_W-1:0] MAX_NEG = {1'b1, {(DATA_W-1){1'b0}}};

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         in_valid;
    logic [PHASE_W-1:0]           wn_exp;
    logic signed [DATA_W-1:0]     a_re, a_im, b_re, b_im;
    logic                         out_valid;
    logic signed [SUM_W-1:0]      x_re, x_im;
    logic signed [PROD_OUT_W-1:0] y_re, y_im;

    // reference model state
    logic signed [TW_W-1:0] model_table [TABLE_DEPTH];
    longint                 exp_x_re_q[$], exp_x_im_q[$], exp_y_re_q[$], exp_y_im_q[$];
    // bit k is the in_valid driven k+1 falling edges ago
    logic [LATENCY-1:0]     valid_hist;
    integer                 seed;
    int                     cycle_count = 0;
    int                     in_count;
    int                     out_count;

    fft_bfly_top #(.DATA_W(DATA_W), .DEPTH(LATENCY - 1)) dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .wn_exp    (wn_exp),
        .a_re      (a_re),
        .a_im      (a_im),
        .b_re      (b_re),
        .b_im      (b_im),
        .out_valid (out_valid),
        .x_re      (x_re),
        .x_im      (x_im),
        .y_re      (y_re),
        .y_im      (y_im)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input longint actual,
                                 input longint expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs();
        compare_value("out_valid", longint'(out_valid), longint'(valid_hist[LATENCY-1]));
        if (out_valid) begin
            if (exp_x_re_q.size() == 0) begin
                $display("an output appeared with no pair left in the model queue");
                stop_with_failure();
            end
            compare_value("x_re", longint'(x_re), exp_x_re_q.pop_front());
            compare_value("x_im", longint'(x_im), exp_x_im_q.pop_front());
            compare_value("y_re", longint'(y_re), exp_y_re_q.pop_front());
            compare_value("y_im", longint'(y_im), exp_y_im_q.pop_front());
            out_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    task automatic model_twiddle(input logic [PHASE_W-1:0] phase,
                                 output longint c, output longint s);
        int     i;
        longint lo, hi;
        i  = int'(phase[QUAD_IDX_W-1:0]);
        lo = longint'(model_table[i]);
        hi = longint'(model_table[QUARTER - i]);
        case (phase[PHASE_W-1 -: 2])
            2'd0: begin
                c = hi;
                s = lo;
            end
            2'd1: begin
                c = -lo;
                s = hi;
            end
            2'd2: begin
                c = -hi;
                s = -lo;
            end
            default: begin
                c = lo;
                s = -hi;
            end
        endcase
    endtask

    function automatic longint wrap_out(input longint v);
        logic signed [PROD_OUT_W-1:0] t;
        t = v[PROD_OUT_W-1:0];
        return longint'(t);
    endfunction

    task automatic push_expected();
        longint dr, di, wr, wi, yr, yi;
        exp_x_re_q.push_back(longint'(a_re) + longint'(b_re));
        exp_x_im_q.push_back(longint'(a_im) + longint'(b_im));
        dr = longint'(a_re) - longint'(b_re);
        di = longint'(a_im) - longint'(b_im);
        if (wn_exp[QUAD_IDX_W-1:0] == '0) begin
            // quarter turns, multiply by 1, j, -1 or -j
            case (wn_exp[PHASE_W-1 -: 2])
                2'd0: begin
                    yr = dr;
                    yi = di;
                end
                2'd1: begin
                    yr = -di;
                    yi = dr;
                end
                2'd2: begin
                    yr = -dr;
                    yi = -di;
                end
                default: begin
                    yr = di;
                    yi = -dr;
                end
            endcase
        end else begin
            model_twiddle(wn_exp, wr, wi);
            yr = (dr * wr - di * wi) >>> TW_FRAC;
            yi = (dr * wi + di * wr) >>> TW_FRAC;
        end
        exp_y_re_q.push_back(wrap_out(yr));
        exp_y_im_q.push_back(wrap_out(yi));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_range(input int n);
        logic [31:0] r;
        r = rand_word();
        return int'(r[7:0]) % n;
    endfunction

    function automatic logic signed [DATA_W-1:0] pick_extreme();
        logic [31:0] r;
        r = rand_word();
        return r[0] ? MAX_POS : MAX_NEG;
    endfunction

    task automatic set_operands(input int n);
        logic [31:0] r;
        if (n % 10 == 9) begin
            a_re = pick_extreme();
            a_im = pick_extreme();
            b_re = pick_extreme();
            b_im = pick_extreme();
        end else begin
            r = rand_word();
            a_re = r[DATA_W-1:0];
            a_im = r[2*DATA_W-1:DATA_W];
            r = rand_word();
            b_re = r[DATA_W-1:0];
            b_im = r[2*DATA_W-1:DATA_W];
        end
        r = rand_word();
        wn_exp = (n < DIRECTED) ? {n[1:0], {QUAD_IDX_W{1'b0}}} : r[PHASE_W-1:0];
    endtask

    // one falling edge: check what came out, then drive the next input
    task automatic drive_cycle(input bit valid, input int n);
        @(negedge clk);
        check_outputs();
        set_operands(n);
        in_valid = valid;
        valid_hist = {valid_hist[LATENCY-2:0], in_valid};
        if (in_valid) begin
            push_expected();
            in_count++;
        end
    endtask

    initial begin
        int vec;
        int burst;
        int gap;
        seed       = 32'h8a9c7c23;
        reset      = 1'b1;
        in_valid   = 1'b0;
        wn_exp     = '0;
        a_re       = '0;
        a_im       = '0;
        b_re       = '0;
        b_im       = '0;
        valid_hist = '0;
        in_count   = 0;
        out_count  = 0;
        $readmemh(TABLE_FILE, model_table);

        repeat (RESET_CYCLES) drive_cycle(1'b0, 0);
        reset = 1'b0;

        // bursts of back-to-back pairs split by short idle gaps
        vec = 0;
        while (vec < NUM_VECTORS) begin
            burst = 1 + rand_range(8);
            gap   = 1 + rand_range(3);
            for (int k = 0; k < burst && vec < NUM_VECTORS; k++) begin
                drive_cycle(1'b1, vec);
                vec++;
            end
            repeat (gap) drive_cycle(1'b0, 0);
        end
        repeat (LATENCY + 2) drive_cycle(1'b0, 0);

        if (exp_x_re_q.size() == 0 && out_count == in_count && in_count == NUM_VECTORS) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("run ended with %0d inputs, %0d outputs and %0d results outstanding",
                     in_count, out_count, exp_x_re_q.size());
            stop_with_failure();
        end
    end

endmodule
